// File: hw/cp0_pkg.sv
`default_nettype none

package cp0_pkg;

    typedef logic [31:0] word_t;
    typedef logic [18:0] vpn2_t;
    typedef logic [19:0] pfn_t;
    typedef logic [7:0]  asid_t;
    typedef logic [7:0]  cp0_addr_t;   // {rd, sel}
    typedef logic [4:0]  exc_code_t;

    localparam cp0_addr_t INDEX_ADDR    = 8'h00;   // rd 0
    localparam cp0_addr_t ENTRYLO0_ADDR = 8'h10;   // rd 2
    localparam cp0_addr_t ENTRYLO1_ADDR = 8'h18;   // rd 3
    localparam cp0_addr_t BADVADDR_ADDR = 8'h40;   // rd 8
    localparam cp0_addr_t COUNT_ADDR    = 8'h48;   // rd 9
    localparam cp0_addr_t ENTRYHI_ADDR  = 8'h50;   // rd 10
    localparam cp0_addr_t COMPARE_ADDR  = 8'h58;   // rd 11
    localparam cp0_addr_t STATUS_ADDR   = 8'h60;   // rd 12
    localparam cp0_addr_t CAUSE_ADDR    = 8'h68;   // rd 13
    localparam cp0_addr_t EPC_ADDR      = 8'h70;   // rd 14

    localparam exc_code_t EXC_INT  = 5'h00;
    localparam exc_code_t EXC_MOD  = 5'h01;
    localparam exc_code_t EXC_TLBL = 5'h02;
    localparam exc_code_t EXC_TLBS = 5'h03;
    localparam exc_code_t EXC_ADEL = 5'h04;
    localparam exc_code_t EXC_ADES = 5'h05;
    localparam exc_code_t EXC_SYS  = 5'h08;

    typedef enum logic [2:0] {
        OP_NONE,
        OP_MTC0,
        OP_ERET,
        OP_TLBR,
        OP_TLBWI,
        OP_TLBP
    } commit_op_t;

    typedef struct packed {
        logic       valid;
        commit_op_t op;
        cp0_addr_t  addr;
        word_t      wdata;
        logic       ex;         // Exception taken
        exc_code_t  exc_code;
        logic       bd;         // In delay slot
        word_t      pc;
        word_t      bad_addr;   // Faulting data address
    } commit_t;

    // One mtc0 write enable per register
    typedef struct packed {
        logic status;
        logic cause;
        logic epc;
        logic badvaddr;
        logic count;
        logic compare;
        logic entryhi;
        logic entrylo0;
        logic entrylo1;
        logic index;
    } reg_we_t;

    // Same bit order as the EntryLo register
    typedef struct packed {
        pfn_t       pfn;
        logic [2:0] c;
        logic       d;
        logic       v;
        logic       g;
    } entrylo_t;

    typedef struct packed {
        vpn2_t    vpn2;
        asid_t    asid;
        logic     g;
        entrylo_t lo0;
        entrylo_t lo1;
    } tlb_entry_t;

    typedef struct packed {
        word_t vaddr;
        asid_t asid;
    } xlate_req_t;

    typedef struct packed {
        logic hit;
        pfn_t pfn;
        logic v;
        logic d;
    } xlate_rsp_t;

endpackage

`default_nettype wire

// File: hw/cp0_ctrl.sv
`timescale 1ns/10ps
`default_nettype none

module cp0_ctrl (
    input  wire                   clk,
    input  wire                   reset,
    input  wire cp0_pkg::commit_t commit,
    input  wire [7:0]             ip,
    output cp0_pkg::reg_we_t      reg_we,
    output logic                  exc_take,
    output logic                  first_exc,
    output logic                  tlbr_go,
    output logic                  tlbwi_go,
    output logic                  tlbp_go,
    output logic                  ex_flush,
    output logic                  eret_flush,
    output logic                  int_pending,
    output cp0_pkg::word_t        status
);
    import cp0_pkg::*;

    logic       normal;
    logic       mtc0_go;
    logic [7:0] im;
    logic       exl;
    logic       ie;

    assign exc_take  = commit.valid && commit.ex;   // Op ignored when ex is set
    assign normal    = commit.valid && !commit.ex;
    assign mtc0_go   = normal && (commit.op == OP_MTC0);
    assign tlbr_go   = normal && (commit.op == OP_TLBR);
    assign tlbwi_go  = normal && (commit.op == OP_TLBWI);
    assign tlbp_go   = normal && (commit.op == OP_TLBP);
    assign first_exc = exc_take && !exl;

    assign ex_flush   = exc_take;
    assign eret_flush = normal && (commit.op == OP_ERET);

    always_comb begin
        reg_we          = '0;
        reg_we.status   = mtc0_go && (commit.addr == STATUS_ADDR);
        reg_we.cause    = mtc0_go && (commit.addr == CAUSE_ADDR);
        reg_we.epc      = mtc0_go && (commit.addr == EPC_ADDR);
        reg_we.badvaddr = mtc0_go && (commit.addr == BADVADDR_ADDR);
        reg_we.count    = mtc0_go && (commit.addr == COUNT_ADDR);
        reg_we.compare  = mtc0_go && (commit.addr == COMPARE_ADDR);
        reg_we.entryhi  = mtc0_go && (commit.addr == ENTRYHI_ADDR);
        reg_we.entrylo0 = mtc0_go && (commit.addr == ENTRYLO0_ADDR);
        reg_we.entrylo1 = mtc0_go && (commit.addr == ENTRYLO1_ADDR);
        reg_we.index    = mtc0_go && (commit.addr == INDEX_ADDR);
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            im  <= '0;
            exl <= 1'b0;
            ie  <= 1'b0;
        end else begin
            if (exc_take)
                exl <= 1'b1;
            else if (eret_flush)
                exl <= 1'b0;
            else if (reg_we.status)
                exl <= commit.wdata[1];
            if (reg_we.status) begin
                im <= commit.wdata[15:8];
                ie <= commit.wdata[0];
            end
        end
    end

    // Bev at bit 22 always reads 1
    assign status = {9'b0, 1'b1, 6'b0, im, 6'b0, exl, ie};

    assign int_pending = ie && !exl && |(ip & im);

    // A commit carries at most one TLB effect and none alongside an exception
    a_excl_strobes: assert property (@(posedge clk) disable iff (reset)
        $onehot0({exc_take, tlbr_go, tlbwi_go, tlbp_go}));

endmodule

`default_nettype wire

// File: hw/cp0_exc_regs.sv
`timescale 1ns/10ps
`default_nettype none

module cp0_exc_regs (
    input  wire                   clk,
    input  wire                   reset,
    input  wire cp0_pkg::commit_t commit,
    input  wire cp0_pkg::reg_we_t reg_we,
    input  wire                   exc_take,
    input  wire                   first_exc,
    input  wire                   ti,
    input  wire [4:0]             ext_int,
    output cp0_pkg::word_t        cause,
    output cp0_pkg::word_t        epc,
    output cp0_pkg::word_t        badvaddr,
    output logic [7:0]            ip
);
    import cp0_pkg::*;

    logic      bd;
    logic [1:0] ip_sw;   // Software interrupts
    exc_code_t exc_code;

    assign ip    = {ti, ext_int, ip_sw};
    assign cause = {bd, ti, 14'b0, ip, 1'b0, exc_code, 2'b0};

    always_ff @(posedge clk) begin
        if (reset) begin
            bd       <= 1'b0;
            ip_sw    <= '0;
            exc_code <= '0;
        end else begin
            if (first_exc)
                bd <= commit.bd;   // Nested exceptions keep the first BD
            if (exc_take)
                exc_code <= commit.exc_code;
            if (reg_we.cause)
                ip_sw <= commit.wdata[9:8];
        end
    end

    // EPC points at the branch when the faulting instruction is in its slot
    always_ff @(posedge clk) begin
        if (first_exc)
            epc <= commit.bd ? commit.pc - 32'd4 : commit.pc;
        else if (reg_we.epc)
            epc <= commit.wdata;
    end

    always_ff @(posedge clk) begin
        if (exc_take) begin
            case (commit.exc_code)
                EXC_ADES, EXC_TLBL, EXC_TLBS, EXC_MOD:
                    badvaddr <= commit.bad_addr;
                EXC_ADEL:
                    badvaddr <= (|commit.pc[1:0]) ? commit.pc : commit.bad_addr;
                default: ;
            endcase
        end
    end

endmodule

`default_nettype wire

// File: hw/cp0_timer.sv
`timescale 1ns/10ps
`default_nettype none

module cp0_timer (
    input  wire                   clk,
    input  wire                   reset,
    input  wire cp0_pkg::commit_t commit,
    input  wire cp0_pkg::reg_we_t reg_we,
    output cp0_pkg::word_t        count,
    output cp0_pkg::word_t        compare,
    output logic                  ti
);
    import cp0_pkg::*;

    logic tick;   // Half-rate phase

    always_ff @(posedge clk) begin
        if (reset) begin
            tick    <= 1'b0;
            count   <= '0;
            compare <= '1;
            ti      <= 1'b0;
        end else begin
            if (reg_we.count) begin
                tick  <= 1'b0;
                count <= commit.wdata;
            end else begin
                tick <= !tick;
                if (tick)
                    count <= count + 32'd1;
            end
            if (reg_we.compare) begin
                compare <= commit.wdata;
                ti      <= 1'b0;   // Write acknowledges the interrupt
            end else if (count == compare) begin
                ti <= 1'b1;
            end
        end
    end

    a_ti_ack: assert property (@(posedge clk) disable iff (reset)
        reg_we.compare |=> !ti);

endmodule

`default_nettype wire

// File: hw/cp0_tlb_regs.sv
`timescale 1ns/10ps
`default_nettype none

module cp0_tlb_regs #(
    parameter int TLB_ENTRIES = 16
) (
    input  wire                                 clk,
    input  wire                                 reset,
    input  wire cp0_pkg::commit_t               commit,
    input  wire cp0_pkg::reg_we_t               reg_we,
    input  wire                                 exc_take,
    input  wire                                 tlbr_go,
    input  wire                                 tlbp_go,
    input  wire cp0_pkg::tlb_entry_t            rd_entry,
    input  wire                                 probe_hit,
    input  wire [$clog2(TLB_ENTRIES)-1:0]       probe_index,
    output cp0_pkg::word_t                      entryhi,
    output cp0_pkg::word_t                      entrylo0,
    output cp0_pkg::word_t                      entrylo1,
    output cp0_pkg::word_t                      index,
    output cp0_pkg::tlb_entry_t                 wr_entry,
    output logic [$clog2(TLB_ENTRIES)-1:0]      sel_index
);
    import cp0_pkg::*;

    localparam int IDX_W = $clog2(TLB_ENTRIES);

    vpn2_t            vpn2;
    asid_t            asid;
    entrylo_t         lo0;
    entrylo_t         lo1;
    logic             idx_p;   // Probe failure
    logic [IDX_W-1:0] idx;
    logic             tlb_exc;

    assign tlb_exc = exc_take && (commit.exc_code == EXC_TLBL ||
                                  commit.exc_code == EXC_TLBS ||
                                  commit.exc_code == EXC_MOD);

    always_ff @(posedge clk) begin
        if (reset) begin
            vpn2  <= '0;
            asid  <= '0;
            lo0   <= '0;
            lo1   <= '0;
            idx_p <= 1'b0;
            idx   <= '0;
        end else begin
            if (tlbr_go) begin
                vpn2 <= rd_entry.vpn2;
                asid <= rd_entry.asid;
                lo0  <= {rd_entry.lo0[25:1], rd_entry.g};   // G comes from the entry
                lo1  <= {rd_entry.lo1[25:1], rd_entry.g};
            end else if (tlb_exc) begin
                vpn2 <= commit.bad_addr[31:13];
            end else if (reg_we.entryhi) begin
                vpn2 <= commit.wdata[31:13];
                asid <= commit.wdata[7:0];
            end
            if (reg_we.entrylo0)
                lo0 <= entrylo_t'(commit.wdata[25:0]);
            if (reg_we.entrylo1)
                lo1 <= entrylo_t'(commit.wdata[25:0]);
            if (tlbp_go) begin
                idx_p <= !probe_hit;
                if (probe_hit)
                    idx <= probe_index;   // Index kept on a miss
            end else if (reg_we.index) begin
                idx <= commit.wdata[IDX_W-1:0];
            end
        end
    end

    assign entryhi  = {vpn2, 5'b0, asid};
    assign entrylo0 = {6'b0, lo0};
    assign entrylo1 = {6'b0, lo1};
    assign index    = {idx_p, {(31 - IDX_W){1'b0}}, idx};

    always_comb begin
        wr_entry      = '0;
        wr_entry.vpn2 = vpn2;
        wr_entry.asid = asid;
        wr_entry.g    = lo0.g && lo1.g;
        wr_entry.lo0  = lo0;
        wr_entry.lo1  = lo1;
    end

    assign sel_index = idx;

endmodule

`default_nettype wire

// File: hw/tlb.sv
`timescale 1ns/10ps
`default_nettype none

module tlb #(
    parameter int TLB_ENTRIES = 16
) (
    input  wire                                 clk,
    input  wire                                 reset,
    input  wire                                 wr_en,
    input  wire [$clog2(TLB_ENTRIES)-1:0]       sel_index,
    input  wire cp0_pkg::tlb_entry_t            wr_entry,
    input  wire cp0_pkg::vpn2_t                 probe_vpn2,
    input  wire cp0_pkg::asid_t                 probe_asid,
    input  wire cp0_pkg::xlate_req_t            xlate_req,
    output cp0_pkg::tlb_entry_t                 rd_entry,
    output logic                                probe_hit,
    output logic [$clog2(TLB_ENTRIES)-1:0]      probe_index,
    output cp0_pkg::xlate_rsp_t                 xlate_rsp
);
    import cp0_pkg::*;

    localparam int IDX_W = $clog2(TLB_ENTRIES);

    tlb_entry_t             entries [TLB_ENTRIES];
    logic [TLB_ENTRIES-1:0] used;          // Written since reset
    logic [TLB_ENTRIES-1:0] probe_match;
    logic [TLB_ENTRIES-1:0] xlate_match;
    entrylo_t               page;

    function automatic logic entry_match(tlb_entry_t e, vpn2_t vpn2, asid_t asid);
        return (e.vpn2 == vpn2) && (e.g || e.asid == asid);
    endfunction

    always_ff @(posedge clk) begin
        if (reset) begin
            used <= '0;
        end else if (wr_en) begin
            used[sel_index] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (wr_en)
            entries[sel_index] <= wr_entry;
    end

    assign rd_entry = entries[sel_index];

    always_comb begin
        for (int i = 0; i < TLB_ENTRIES; i++) begin
            probe_match[i] = used[i] && entry_match(entries[i], probe_vpn2, probe_asid);
            xlate_match[i] = used[i] &&
                             entry_match(entries[i], xlate_req.vaddr[31:13], xlate_req.asid);
        end
    end

    // Tlbp search on the staged EntryHi
    always_comb begin
        probe_index = '0;
        for (int i = 0; i < TLB_ENTRIES; i++) begin
            if (probe_match[i])
                probe_index = IDX_W'(i);
        end
    end

    assign probe_hit = |probe_match;

    // Memory stage lookup where bit 12 picks the odd page
    always_comb begin
        page = '0;
        for (int i = 0; i < TLB_ENTRIES; i++) begin
            if (xlate_match[i])
                page = xlate_req.vaddr[12] ? entries[i].lo1 : entries[i].lo0;
        end
        xlate_rsp     = '0;
        xlate_rsp.hit = |xlate_match;
        xlate_rsp.pfn = page.pfn;
        xlate_rsp.v   = page.v;
        xlate_rsp.d   = page.d;
    end

    a_probe_unique: assert property (@(posedge clk) disable iff (reset)
        $onehot0(probe_match));

endmodule

`default_nettype wire

// File: hw/cp0_top.sv
`timescale 1ns/10ps
`default_nettype none

module cp0_top #(
    parameter int TLB_ENTRIES = 16
) (
    input  wire                      clk,
    input  wire                      reset,
    input  wire cp0_pkg::commit_t    commit,
    input  wire [4:0]                ext_int,
    input  wire cp0_pkg::cp0_addr_t  rd_addr,
    input  wire cp0_pkg::xlate_req_t xlate_req,
    output cp0_pkg::word_t           rd_data,
    output cp0_pkg::xlate_rsp_t      xlate_rsp,
    output logic                     ex_flush,
    output logic                     eret_flush,
    output cp0_pkg::word_t           epc,
    output logic                     int_pending
);
    import cp0_pkg::*;

    localparam int IDX_W = $clog2(TLB_ENTRIES);

    reg_we_t          reg_we;
    logic             exc_take;
    logic             first_exc;
    logic             tlbr_go;
    logic             tlbwi_go;
    logic             tlbp_go;
    logic [7:0]       ip;
    logic             ti;
    word_t            status;
    word_t            cause;
    word_t            badvaddr;
    word_t            count;
    word_t            compare;
    word_t            entryhi;
    word_t            entrylo0;
    word_t            entrylo1;
    word_t            index;
    tlb_entry_t       rd_entry;
    tlb_entry_t       wr_entry;
    logic             probe_hit;
    logic [IDX_W-1:0] probe_index;
    logic [IDX_W-1:0] sel_index;

    cp0_ctrl u_ctrl (
        .clk, .reset, .commit, .ip, .reg_we, .exc_take, .first_exc,
        .tlbr_go, .tlbwi_go, .tlbp_go, .ex_flush, .eret_flush, .int_pending, .status
    );

    cp0_exc_regs u_exc_regs (
        .clk, .reset, .commit, .reg_we, .exc_take, .first_exc, .ti, .ext_int,
        .cause, .epc, .badvaddr, .ip
    );

    cp0_timer u_timer (
        .clk, .reset, .commit, .reg_we, .count, .compare, .ti
    );

    cp0_tlb_regs #(.TLB_ENTRIES(TLB_ENTRIES)) u_tlb_regs (
        .clk, .reset, .commit, .reg_we, .exc_take, .tlbr_go, .tlbp_go, .rd_entry,
        .probe_hit, .probe_index, .entryhi, .entrylo0, .entrylo1, .index,
        .wr_entry, .sel_index
    );

    tlb #(.TLB_ENTRIES(TLB_ENTRIES)) u_tlb (
        .clk,
        .reset,
        .wr_en      (tlbwi_go),
        .sel_index,
        .wr_entry,
        .probe_vpn2 (entryhi[31:13]),
        .probe_asid (entryhi[7:0]),
        .xlate_req,
        .rd_entry,
        .probe_hit,
        .probe_index,
        .xlate_rsp
    );

    // Mfc0 read port
    always_comb begin
        case (rd_addr)
            STATUS_ADDR:   rd_data = status;
            CAUSE_ADDR:    rd_data = cause;
            EPC_ADDR:      rd_data = epc;
            BADVADDR_ADDR: rd_data = badvaddr;
            COUNT_ADDR:    rd_data = count;
            COMPARE_ADDR:  rd_data = compare;
            ENTRYHI_ADDR:  rd_data = entryhi;
            ENTRYLO0_ADDR: rd_data = entrylo0;
            ENTRYLO1_ADDR: rd_data = entrylo1;
            INDEX_ADDR:    rd_data = index;
            default:       rd_data = '0;   // Unimplemented
        endcase
    end

endmodule

`default_nettype wire

// File: tests/cp0_tb_tasks.svh
localparam vpn2_t VPN2_A = 19'h01234;
localparam vpn2_t VPN2_B = 19'h05678;
localparam vpn2_t VPN2_X = 19'h70000;   // Never written

word_t hi_a;
word_t lo0_a;
word_t lo1_a;
word_t hi_b;
word_t lo0_b;
word_t lo1_b;

task automatic check_eq(input string what, input word_t expected, input word_t actual);
    checks++;
    if (expected !== actual) begin
        errors++;
        $display("error %s %s: expected %h, actual %h", test_name, what, expected, actual);
    end
endtask

task automatic step();
    @(posedge clk);
    #1;
endtask

// Flags are {ex_flush, eret_flush} in the strobe cycle and in the cycle after
task automatic send_commit(input commit_t c, output logic [1:0] during,
                           output logic [1:0] after);
    step();
    commit = c;
    #1;
    during = {ex_flush, eret_flush};
    step();
    commit = '0;
    #1;
    after = {ex_flush, eret_flush};
endtask

task automatic write_reg(input cp0_addr_t addr, input word_t data);
    commit_t    c;
    logic [1:0] during;
    logic [1:0] after;
    c       = '0;
    c.valid = 1'b1;
    c.op    = OP_MTC0;
    c.addr  = addr;
    c.wdata = data;
    send_commit(c, during, after);
endtask

task automatic run_op(input commit_op_t op, output logic [1:0] during,
                      output logic [1:0] after);
    commit_t c;
    c       = '0;
    c.valid = 1'b1;
    c.op    = op;
    send_commit(c, during, after);
endtask

task automatic raise(input exc_code_t code, input logic bd, input word_t pc,
                     input word_t bad, input commit_op_t op);
    commit_t    c;
    logic [1:0] during;
    logic [1:0] after;
    c          = '0;
    c.valid    = 1'b1;
    c.op       = op;
    c.ex       = 1'b1;
    c.exc_code = code;
    c.bd       = bd;
    c.pc       = pc;
    c.bad_addr = bad;
    send_commit(c, during, after);
    check_eq("flush during", 2'b10, during);
    check_eq("flush after", 2'b00, after);   // One cycle only
endtask

task automatic read_reg(input cp0_addr_t addr, output word_t data);
    rd_addr = addr;
    #1;
    data = rd_data;
endtask

task automatic lookup(input word_t vaddr, input asid_t asid, output xlate_rsp_t rsp);
    step();
    xlate_req.vaddr = vaddr;
    xlate_req.asid  = asid;
    #1;
    rsp = xlate_rsp;
endtask

function automatic word_t entry_lo(input word_t pfn, input logic d, input logic v,
                                   input logic g);
    return {6'b0, pfn[19:0], 3'd3, d, v, g};   // C field fixed at 3
endfunction

task automatic load_entry(input word_t idx, input word_t hi, input word_t lo0,
                          input word_t lo1);
    logic [1:0] during;
    logic [1:0] after;
    write_reg(INDEX_ADDR, idx);
    write_reg(ENTRYHI_ADDR, hi);
    write_reg(ENTRYLO0_ADDR, lo0);
    write_reg(ENTRYLO1_ADDR, lo1);
    run_op(OP_TLBWI, during, after);
endtask

task automatic test_reset_values();
    word_t rd;
    test_name = "reset";
    check_eq("ex_flush", 0, ex_flush);
    check_eq("eret_flush", 0, eret_flush);
    check_eq("int_pending", 0, int_pending);
    read_reg(STATUS_ADDR, rd);
    check_eq("status", 32'h0040_0000, rd);   // Only Bev set
    read_reg(CAUSE_ADDR, rd);
    check_eq("cause", 0, rd);
    read_reg(COMPARE_ADDR, rd);
    check_eq("compare", 32'hffff_ffff, rd);
    read_reg(COUNT_ADDR, rd);
    check_eq("count", 0, rd);
endtask

task automatic test_readback();
    word_t w;
    word_t rd;
    test_name = "readback";
    w = $urandom;
    write_reg(STATUS_ADDR, w);
    read_reg(STATUS_ADDR, rd);
    check_eq("status", (w & 32'h0000_ff03) | 32'h0040_0000, rd);
    w = $urandom;
    write_reg(CAUSE_ADDR, w);
    read_reg(CAUSE_ADDR, rd);
    check_eq("cause", w & 32'h0000_0300, rd);   // IP1..0 only
    w = $urandom;
    write_reg(EPC_ADDR, w);
    read_reg(EPC_ADDR, rd);
    check_eq("epc", w, rd);
    w = $urandom;
    write_reg(ENTRYHI_ADDR, w);
    read_reg(ENTRYHI_ADDR, rd);
    check_eq("entryhi", w & 32'hffff_e0ff, rd);
    w = $urandom;
    write_reg(ENTRYLO0_ADDR, w);
    read_reg(ENTRYLO0_ADDR, rd);
    check_eq("entrylo0", w & 32'h03ff_ffff, rd);
    w = $urandom;
    write_reg(ENTRYLO1_ADDR, w);
    read_reg(ENTRYLO1_ADDR, rd);
    check_eq("entrylo1", w & 32'h03ff_ffff, rd);
    write_reg(STATUS_ADDR, 0);   // Leave EXL and IE clear
    write_reg(CAUSE_ADDR, 0);
endtask

task automatic check_exc_state(input word_t epc_exp, input logic bd, input exc_code_t code,
                               input word_t bad_exp);
    word_t rd;
    read_reg(EPC_ADDR, rd);
    check_eq("epc", epc_exp, rd);
    check_eq("epc port", epc_exp, epc);
    read_reg(CAUSE_ADDR, rd);
    check_eq("cause bd", bd, rd[31]);
    check_eq("cause exccode", code, rd[6:2]);
    read_reg(BADVADDR_ADDR, rd);
    check_eq("badvaddr", bad_exp, rd);
    read_reg(STATUS_ADDR, rd);
    check_eq("status exl", 1, rd[1]);
endtask

task automatic do_eret();
    logic [1:0] during;
    logic [1:0] after;
    word_t      rd;
    run_op(OP_ERET, during, after);
    check_eq("eret flush during", 2'b01, during);
    check_eq("eret flush after", 2'b00, after);
    read_reg(STATUS_ADDR, rd);
    check_eq("exl after eret", 0, rd[1]);
endtask

task automatic test_exceptions();
    word_t bad;
    test_name = "exceptions";
    bad = $urandom;
    raise(EXC_ADES, 1'b0, 32'h8000_0100, bad, OP_NONE);
    check_exc_state(32'h8000_0100, 1'b0, EXC_ADES, bad);
    do_eret();
    // Sys in a delay slot leaves BadVAddr alone
    raise(EXC_SYS, 1'b1, 32'h8000_0204, $urandom, OP_NONE);
    check_exc_state(32'h8000_0200, 1'b1, EXC_SYS, bad);
    // Nested misaligned fetch whose op is ignored
    raise(EXC_ADEL, 1'b0, 32'h8000_0302, $urandom, OP_ERET);
    check_exc_state(32'h8000_0200, 1'b1, EXC_ADEL, 32'h8000_0302);
    do_eret();
endtask

task automatic test_timer();
    word_t c0;
    word_t cnt;
    word_t rd;
    logic  seen;
    test_name = "timer";
    write_reg(STATUS_ADDR, 32'h0000_8001);   // IE and IM7
    c0 = $urandom & 32'h0fff_ffff;
    write_reg(COUNT_ADDR, c0);
    read_reg(COUNT_ADDR, rd);
    check_eq("count load", c0, rd);
    repeat (4) step();
    read_reg(COUNT_ADDR, cnt);
    check_eq("count half rate", c0 + 2, cnt);
    write_reg(COMPARE_ADDR, cnt + 3);
    read_reg(CAUSE_ADDR, rd);
    check_eq("ti after compare write", 0, rd[30]);
    check_eq("int_pending before ti", 0, int_pending);
    seen = 1'b0;
    for (int n = 0; n < 32 && !seen; n++) begin
        read_reg(CAUSE_ADDR, rd);
        if (rd[30])
            seen = 1'b1;
        else
            step();
    end
    if (!seen) begin
        errors++;
        $display("%s: timer interrupt did not arrive within 32 cycles", test_name);
    end
    check_eq("int_pending on ti", 1, int_pending);
    write_reg(STATUS_ADDR, 32'h0000_8003);
    check_eq("masked by exl", 0, int_pending);
    write_reg(STATUS_ADDR, 32'h0000_0001);
    check_eq("masked by im7", 0, int_pending);
    write_reg(STATUS_ADDR, 32'h0000_8000);
    check_eq("masked by ie", 0, int_pending);
    write_reg(STATUS_ADDR, 32'h0000_8001);
    check_eq("unmasked again", 1, int_pending);
    write_reg(COMPARE_ADDR, cnt + 1000);
    read_reg(CAUSE_ADDR, rd);
    check_eq("ti cleared", 0, rd[30]);
    check_eq("int_pending cleared", 0, int_pending);
    write_reg(STATUS_ADDR, 0);
endtask

task automatic test_tlb_lookup();
    xlate_rsp_t r;
    test_name = "tlb lookup";
    hi_a  = {VPN2_A, 5'b0, 8'h11};
    lo0_a = entry_lo($urandom, 1'b1, 1'b1, 1'b1);
    lo1_a = entry_lo($urandom, 1'b0, 1'b1, 1'b1);
    hi_b  = {VPN2_B, 5'b0, 8'h22};
    lo0_b = entry_lo($urandom, 1'b1, 1'b1, 1'b1);   // G on one page only
    lo1_b = entry_lo($urandom, 1'b0, 1'b0, 1'b0);   // Invalid odd page
    load_entry(2, hi_a, lo0_a, lo1_a);
    load_entry(5, hi_b, lo0_b, lo1_b);
    lookup({VPN2_A, 1'b0, 12'h123}, 8'h99, r);
    check_eq("global even hit", 1, r.hit);
    check_eq("global even pfn", lo0_a[25:6], r.pfn);
    lookup({VPN2_A, 1'b1, 12'h456}, 8'h99, r);
    check_eq("global odd hit", 1, r.hit);
    check_eq("global odd pfn", lo1_a[25:6], r.pfn);
    check_eq("global odd d", 0, r.d);
    lookup({VPN2_B, 1'b0, 12'h000}, 8'h22, r);
    check_eq("asid even hit", 1, r.hit);
    check_eq("asid even pfn", lo0_b[25:6], r.pfn);
    check_eq("asid even vd", 2'b11, {r.v, r.d});
    lookup({VPN2_B, 1'b0, 12'h000}, 8'h33, r);
    check_eq("wrong asid", 0, r.hit);
    lookup({VPN2_B, 1'b1, 12'hffc}, 8'h22, r);
    check_eq("invalid page hit", 1, r.hit);
    check_eq("invalid page v", 0, r.v);
    lookup({VPN2_X, 1'b0, 12'h000}, 8'h22, r);
    check_eq("absent page", 0, r.hit);
endtask

task automatic test_probe_read();
    word_t      rd;
    logic [1:0] during;
    logic [1:0] after;
    test_name = "probe and read";
    write_reg(ENTRYHI_ADDR, hi_b);
    run_op(OP_TLBP, during, after);
    read_reg(INDEX_ADDR, rd);
    check_eq("probe asid entry", 5, rd);
    write_reg(ENTRYHI_ADDR, {VPN2_X, 5'b0, 8'h22});
    run_op(OP_TLBP, during, after);
    read_reg(INDEX_ADDR, rd);
    check_eq("probe absent", 32'h8000_0005, rd);   // Index field kept
    write_reg(ENTRYHI_ADDR, {VPN2_A, 5'b0, 8'h77});
    run_op(OP_TLBP, during, after);
    read_reg(INDEX_ADDR, rd);
    check_eq("probe global entry", 2, rd);
    write_reg(ENTRYHI_ADDR, {VPN2_B, 5'b0, 8'h33});
    run_op(OP_TLBP, during, after);
    read_reg(INDEX_ADDR, rd);
    check_eq("probe wrong asid", 32'h8000_0002, rd);
    write_reg(INDEX_ADDR, 5);
    write_reg(ENTRYLO0_ADDR, $urandom);
    write_reg(ENTRYLO1_ADDR, $urandom);
    run_op(OP_TLBR, during, after);
    read_reg(ENTRYHI_ADDR, rd);
    check_eq("tlbr entryhi b", hi_b, rd);
    read_reg(ENTRYLO0_ADDR, rd);
    check_eq("tlbr entrylo0 b", {lo0_b[31:1], 1'b0}, rd);   // Entry is not global
    read_reg(ENTRYLO1_ADDR, rd);
    check_eq("tlbr entrylo1 b", lo1_b, rd);
    write_reg(INDEX_ADDR, 2);
    run_op(OP_TLBR, during, after);
    read_reg(ENTRYHI_ADDR, rd);
    check_eq("tlbr entryhi a", hi_a, rd);
    read_reg(ENTRYLO0_ADDR, rd);
    check_eq("tlbr entrylo0 a", lo0_a, rd);
    read_reg(ENTRYLO1_ADDR, rd);
    check_eq("tlbr entrylo1 a", lo1_a, rd);
endtask

// File: tests/cp0_tb.sv
`timescale 1ns/10ps
`default_nettype none

module cp0_tb;
    import cp0_pkg::*;

    logic       clk;
    logic       reset;
    commit_t    commit;
    logic [4:0] ext_int;
    cp0_addr_t  rd_addr;
    xlate_req_t xlate_req;
    word_t      rd_data;
    xlate_rsp_t xlate_rsp;
    logic       ex_flush;
    logic       eret_flush;
    word_t      epc;
    logic       int_pending;

    int    errors;
    int    checks;
    string test_name;   // Shown in error lines

    cp0_top #(.TLB_ENTRIES(16)) uut (
        .clk,
        .reset,
        .commit,
        .ext_int,
        .rd_addr,
        .xlate_req,
        .rd_data,
        .xlate_rsp,
        .ex_flush,
        .eret_flush,
        .epc,
        .int_pending
    );

    always #4 clk = ~clk;   // 8 ns period

    `include "cp0_tb_tasks.svh"

    initial begin
        void'($urandom(1));
        clk       = 1'b0;
        reset     = 1'b1;
        commit    = '0;
        ext_int   = '0;
        rd_addr   = '0;
        xlate_req = '0;
        errors    = 0;
        checks    = 0;
        test_name = "reset";

        repeat (16) @(posedge clk);
        #1;
        reset = 1'b0;

        test_reset_values();
        test_readback();
        test_exceptions();
        test_timer();
        test_tlb_lookup();
        test_probe_read();

        $display("%0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: verilog.f
+incdir+tests
hw/cp0_pkg.sv
hw/cp0_ctrl.sv
hw/cp0_exc_regs.sv
hw/cp0_timer.sv
hw/cp0_tlb_regs.sv
hw/tlb.sv
hw/cp0_top.sv
tests/cp0_tb.sv
